//--- verilog/resp_stats_pkg.sv
// Response statistics shared types

`default_nettype none

package resp_stats_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and counts
  ////////////////////////////////////////////////////////////////////////////

  localparam int tag_bits        = 6;
  localparam int count_bits      = 32;
  localparam int stat_words      = 19;
  localparam int stat_index_bits = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Host bus response codes, gaps in the encoding are unknown codes
  typedef enum logic [7:0] {
    done    = 8'h00,
    aerror  = 8'h01,
    derror  = 8'h03,
    nlock   = 8'h04,
    nres    = 8'h05,
    flushed = 8'h06,
    fault   = 8'h07,
    failed  = 8'h08,
    paged   = 8'h0A
  } response_code_t;

  typedef enum logic [2:0] {
    cmd_invalid,
    cmd_read,
    cmd_write,
    cmd_prefetch_read,
    cmd_prefetch_write,
    cmd_restart
  } command_type_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                valid;
    logic [tag_bits-1:0] tag;
    command_type_t       cmd_type;
    logic [7:0]          real_size_bytes;
  } command_issue_t;

  typedef struct packed {
    logic                valid;
    logic [tag_bits-1:0] tag;
    response_code_t      code;
  } response_t;

  // What the table remembers per outstanding tag
  typedef struct packed {
    command_type_t cmd_type;
    logic [7:0]    real_size_bytes;
  } command_tag_line_t;

  // Field order is the readout index, done is index 0
  typedef struct packed {
    logic [count_bits-1:0] done;
    logic [count_bits-1:0] flushed;
    logic [count_bits-1:0] paged;
    logic [count_bits-1:0] aerror;
    logic [count_bits-1:0] derror;
    logic [count_bits-1:0] failed;
    logic [count_bits-1:0] fault;
    logic [count_bits-1:0] nres;
    logic [count_bits-1:0] nlock;
    logic [count_bits-1:0] done_restart;
    logic [count_bits-1:0] done_prefetch_read;
    logic [count_bits-1:0] done_prefetch_write;
    logic [count_bits-1:0] done_read;
    logic [count_bits-1:0] done_write;
    logic [count_bits-1:0] prefetch_read_bytes;
    logic [count_bits-1:0] prefetch_write_bytes;
    logic [count_bits-1:0] read_bytes;
    logic [count_bits-1:0] write_bytes;
    logic [count_bits-1:0] cycle;
  } response_statistics_t;

endpackage

`default_nettype wire

//--- verilog/command_tag_table.sv
// Command tag table

`default_nettype none

module command_tag_table (
  input  logic                                  clock,
  input  logic                                  rstn,
  input  resp_stats_pkg::command_issue_t        command_issue,
  input  logic [resp_stats_pkg::tag_bits-1:0]   response_tag,
  output resp_stats_pkg::command_tag_line_t     tag_line
);

  import resp_stats_pkg::*;

  localparam int entries = 2 ** tag_bits;

  command_tag_line_t table_q [entries];

  ////////////////////////////////////////////////////////////////////////////
  // Write on issue
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < entries; i++) begin
        table_q[i] <= '{cmd_type: cmd_invalid, real_size_bytes: 8'd0};
      end
    end else if (command_issue.valid) begin
      table_q[command_issue.tag] <= '{cmd_type: command_issue.cmd_type,
                                      real_size_bytes: command_issue.real_size_bytes};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered lookup by response tag
  ////////////////////////////////////////////////////////////////////////////

  // Follows the response by one cycle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_line <= '{cmd_type: cmd_invalid, real_size_bytes: 8'd0};
    end else begin
      tag_line <= table_q[response_tag];
    end
  end

endmodule

`default_nettype wire

//--- verilog/response_decode.sv
// Response decode pipeline

`default_nettype none

module response_decode (
  input  logic                              clock,
  input  logic                              rstn,
  input  logic                              enabled_in,
  input  resp_stats_pkg::response_t         response,
  input  resp_stats_pkg::command_tag_line_t tag_line,
  output logic                              enabled,
  output resp_stats_pkg::response_t         stage2_response,
  output resp_stats_pkg::command_tag_line_t stage2_line
);

  import resp_stats_pkg::*;

  response_t stage1_response;

  // Enable is one cycle late relative to the pin
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enabled_in;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Two gated stages
  ////////////////////////////////////////////////////////////////////////////

  // Empty slots are zeroed so a stale response never counts twice
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      stage1_response <= '0;
      stage2_response <= '0;
    end else begin
      if (enabled && response.valid) begin
        stage1_response <= response;
      end else begin
        stage1_response <= '0;
      end
      if (enabled && stage1_response.valid) begin
        stage2_response <= stage1_response;
      end else begin
        stage2_response <= '0;
      end
    end
  end

  // Table output already trails by one cycle, one more register aligns it
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      stage2_line <= '0;
    end else begin
      stage2_line <= tag_line;
    end
  end

endmodule

`default_nettype wire

//--- verilog/response_statistics_control.sv
// Response statistics counters

`default_nettype none

module response_statistics_control (
  input  logic                                 clock,
  input  logic                                 rstn,
  input  logic                                 enabled,
  input  resp_stats_pkg::response_t            stage2_response,
  input  resp_stats_pkg::command_tag_line_t    stage2_line,
  output resp_stats_pkg::response_statistics_t statistics
);

  import resp_stats_pkg::*;

  logic [count_bits-1:0] size_ext;
  logic                  count_done;

  assign size_ext   = count_bits'(stage2_line.real_size_bytes);
  assign count_done = stage2_response.valid && (stage2_response.code == done);

  ////////////////////////////////////////////////////////////////////////////
  // Counter bank
  ////////////////////////////////////////////////////////////////////////////

  // Everything holds while disabled, counters wrap
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      statistics <= '0;
    end else if (enabled) begin
      statistics.cycle <= statistics.cycle + count_bits'(1);

      // One counter per known code
      if (stage2_response.valid) begin
        case (stage2_response.code)
          done: begin
            statistics.done <= statistics.done + count_bits'(1);
          end
          flushed: begin
            statistics.flushed <= statistics.flushed + count_bits'(1);
          end
          paged: begin
            statistics.paged <= statistics.paged + count_bits'(1);
          end
          aerror: begin
            statistics.aerror <= statistics.aerror + count_bits'(1);
          end
          derror: begin
            statistics.derror <= statistics.derror + count_bits'(1);
          end
          failed: begin
            statistics.failed <= statistics.failed + count_bits'(1);
          end
          fault: begin
            statistics.fault <= statistics.fault + count_bits'(1);
          end
          nres: begin
            statistics.nres <= statistics.nres + count_bits'(1);
          end
          nlock: begin
            statistics.nlock <= statistics.nlock + count_bits'(1);
          end
          default: begin
          end
        endcase
      end

      // Completions by command type, a restart moves no data
      if (count_done) begin
        case (stage2_line.cmd_type)
          cmd_restart: begin
            statistics.done_restart <= statistics.done_restart + count_bits'(1);
          end
          cmd_prefetch_read: begin
            statistics.done_prefetch_read <= statistics.done_prefetch_read + count_bits'(1);
            statistics.prefetch_read_bytes <= statistics.prefetch_read_bytes + size_ext;
          end
          cmd_prefetch_write: begin
            statistics.done_prefetch_write <= statistics.done_prefetch_write + count_bits'(1);
            statistics.prefetch_write_bytes <= statistics.prefetch_write_bytes + size_ext;
          end
          cmd_read: begin
            statistics.done_read <= statistics.done_read + count_bits'(1);
            statistics.read_bytes <= statistics.read_bytes + size_ext;
          end
          cmd_write: begin
            statistics.done_write <= statistics.done_write + count_bits'(1);
            statistics.write_bytes <= statistics.write_bytes + size_ext;
          end
          // Tag never issued
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/stats_readout.sv
// Statistics snapshot and readout

`default_nettype none

module stats_readout (
  input  logic                                       clock,
  input  logic                                       rstn,
  input  logic                                       snapshot,
  input  resp_stats_pkg::response_statistics_t       statistics,
  input  logic [resp_stats_pkg::stat_index_bits-1:0] read_index,
  output logic [resp_stats_pkg::count_bits-1:0]      read_data
);

  import resp_stats_pkg::*;

  response_statistics_t snapshot_stats;

  // Word 0 sits at the top of the struct, so count up from the left
  logic [0:stat_words-1][count_bits-1:0] snapshot_words;

  assign snapshot_words = snapshot_stats;

  ////////////////////////////////////////////////////////////////////////////
  // Frozen copy
  ////////////////////////////////////////////////////////////////////////////

  // All words from one edge, so a multi-word read is consistent
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      snapshot_stats <= '0;
    end else if (snapshot) begin
      snapshot_stats <= statistics;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Word select
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      read_data <= '0;
    end else if (read_index < stat_index_bits'(stat_words)) begin
      read_data <= snapshot_words[read_index];
    end else begin
      read_data <= '0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/response_stats_top.sv
// Response statistics top level

`default_nettype none

module response_stats_top (
  input  logic                                       clock,
  input  logic                                       rstn,
  input  logic                                       enabled_in,
  input  logic                                       snapshot,
  input  resp_stats_pkg::command_issue_t             command_issue,
  input  resp_stats_pkg::response_t                  response,
  input  logic [resp_stats_pkg::stat_index_bits-1:0] read_index,
  output logic [resp_stats_pkg::count_bits-1:0]      read_data
);

  import resp_stats_pkg::*;

  command_tag_line_t    tag_line;
  command_tag_line_t    stage2_line;
  response_t            stage2_response;
  response_statistics_t statistics;
  logic                 enabled;

  command_tag_table u_tag_table (
    .clock         (clock),
    .rstn          (rstn),
    .command_issue (command_issue),
    .response_tag  (response.tag),
    .tag_line      (tag_line)
  );

  response_decode u_decode (
    .clock           (clock),
    .rstn            (rstn),
    .enabled_in      (enabled_in),
    .response        (response),
    .tag_line        (tag_line),
    .enabled         (enabled),
    .stage2_response (stage2_response),
    .stage2_line     (stage2_line)
  );

  response_statistics_control u_stats (
    .clock           (clock),
    .rstn            (rstn),
    .enabled         (enabled),
    .stage2_response (stage2_response),
    .stage2_line     (stage2_line),
    .statistics      (statistics)
  );

  stats_readout u_readout (
    .clock      (clock),
    .rstn       (rstn),
    .snapshot   (snapshot),
    .statistics (statistics),
    .read_index (read_index),
    .read_data  (read_data)
  );

endmodule

`default_nettype wire

//--- dv/response_stats_chk.sv
// Response statistics assertions

`default_nettype none

module response_stats_chk (
  input wire logic                                  clock,
  input wire logic                                  rstn,
  input wire logic                                  enabled,
  input wire resp_stats_pkg::response_t             stage2_response,
  input wire resp_stats_pkg::response_statistics_t  statistics,
  input wire logic [resp_stats_pkg::count_bits-1:0] read_data
);

  timeunit 1ns;
  timeprecision 100ps;

  int failures = 0;

  reset_readout: assert property (@(posedge clock) !rstn |-> read_data == '0)
    else begin
      failures++;
      $error("read_data not zero while reset is held");
    end

  // Counters sit still one edge after a low enable
  hold_disabled: assert property (@(posedge clock) disable iff (!rstn)
    !enabled |=> $stable(statistics))
    else begin
      failures++;
      $error("statistics changed while disabled");
    end

  valid_enabled: assert property (@(posedge clock) disable iff (!rstn)
    stage2_response.valid |-> enabled)
    else begin
      failures++;
      $error("stage 2 valid without enable");
    end

endmodule

bind response_stats_top response_stats_chk u_chk (
  .clock           (clock),
  .rstn            (rstn),
  .enabled         (enabled),
  .stage2_response (stage2_response),
  .statistics      (statistics),
  .read_data       (read_data)
);

`default_nettype wire

//--- dv/response_stats_tb.sv
// Response statistics testbench

`default_nettype none

module response_stats_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import resp_stats_pkg::*;

  // Row layout. Size bit 8 or tag bit 6 set means use a random value
  typedef struct packed {
    logic [79:0]   name;
    command_type_t cmd_type;
    logic [8:0]    size;
    logic [6:0]    tag;
    logic [7:0]    code;
    logic          enable;
    logic [1:0]    check;
  } stim_row_t;

  localparam logic [8:0] rnd_size       = 9'h100;
  localparam logic [6:0] rnd_tag        = 7'h40;
  localparam int         num_rows       = 20;
  localparam int         timeout_cycles = num_rows * 40 + 200;

  // Check column, 1 snapshots then reads, 2 reads the old snapshot again
  stim_row_t rows [num_rows] = '{
    '{"done_read",  cmd_read,           rnd_size, rnd_tag, 8'h00, 1'b1, 2'd0},
    '{"aerror",     cmd_write,          rnd_size, rnd_tag, 8'h01, 1'b1, 2'd0},
    '{"derror",     cmd_read,           rnd_size, rnd_tag, 8'h03, 1'b1, 2'd0},
    '{"nlock",      cmd_read,           rnd_size, rnd_tag, 8'h04, 1'b1, 2'd0},
    '{"nres",       cmd_write,          rnd_size, rnd_tag, 8'h05, 1'b1, 2'd0},
    '{"flushed",    cmd_read,           rnd_size, rnd_tag, 8'h06, 1'b1, 2'd0},
    '{"fault",      cmd_write,          rnd_size, rnd_tag, 8'h07, 1'b1, 2'd0},
    '{"failed",     cmd_read,           rnd_size, rnd_tag, 8'h08, 1'b1, 2'd0},
    '{"paged",      cmd_write,          rnd_size, rnd_tag, 8'h0A, 1'b1, 2'd1},
    '{"done_write", cmd_write,          9'd200,   7'd5,    8'h00, 1'b1, 2'd0},
    '{"done_pfr",   cmd_prefetch_read,  rnd_size, 7'd9,    8'h00, 1'b1, 2'd0},
    '{"done_pfw",   cmd_prefetch_write, rnd_size, rnd_tag, 8'h00, 1'b1, 2'd0},
    '{"done_rst",   cmd_restart,        9'd64,    rnd_tag, 8'h00, 1'b1, 2'd0},
    '{"done_inv",   cmd_invalid,        9'd0,     7'd63,   8'h00, 1'b1, 2'd1},
    '{"unknown",    cmd_read,           rnd_size, rnd_tag, 8'h02, 1'b1, 2'd1},
    '{"dis_done",   cmd_read,           rnd_size, rnd_tag, 8'h00, 1'b0, 2'd0},
    '{"dis_fault",  cmd_write,          rnd_size, rnd_tag, 8'h07, 1'b0, 2'd1},
    '{"re_enable",  cmd_write,          9'd255,   rnd_tag, 8'h00, 1'b1, 2'd1},
    '{"post_snap",  cmd_read,           rnd_size, rnd_tag, 8'h00, 1'b1, 2'd2},
    '{"final_pfw",  cmd_prefetch_write, rnd_size, rnd_tag, 8'h00, 1'b1, 2'd1}
  };

  logic                       clock;
  logic                       rstn;
  logic                       enabled_in;
  logic                       snapshot;
  command_issue_t             command_issue;
  response_t                  response;
  logic [stat_index_bits-1:0] read_index;
  logic [count_bits-1:0]      read_data;

  logic [31:0] model [stat_words];
  logic [31:0] snap_model [stat_words];
  logic [31:0] rng = 32'h6446_f86b;
  int          snap_cycles = 0;
  int          enabled_cycles = 0;
  int          cycles_run = 0;
  int          checks = 0;
  int          errors = 0;

  response_stats_top DUT (
    .clock         (clock),
    .rstn          (rstn),
    .enabled_in    (enabled_in),
    .snapshot      (snapshot),
    .command_issue (command_issue),
    .response      (response),
    .read_index    (read_index),
    .read_data     (read_data)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Edges seen with the enable pin high, the DUT count trails this by one
  always @(posedge clock) begin
    if (rstn && enabled_in) begin
      enabled_cycles <= enabled_cycles + 1;
    end
  end

  always @(posedge clock) begin
    cycles_run <= cycles_run + 1;
    if (cycles_run >= timeout_cycles) begin
      $display("Timeout, the run did not finish within %0d cycles", timeout_cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Readout index of the counter for a response code
  function automatic int code_slot(input logic [7:0] code);
    case (code)
      8'h00: return 0;
      8'h06: return 1;
      8'h0A: return 2;
      8'h01: return 3;
      8'h03: return 4;
      8'h08: return 5;
      8'h07: return 6;
      8'h05: return 7;
      8'h04: return 8;
      default: return -1;
    endcase
  endfunction

  task automatic step();
    @(posedge clock);
    #2;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic update_model(input command_type_t cmd_type, input logic [7:0] size,
                              input logic [7:0] code);
    int slot;
    slot = code_slot(code);
    if (slot >= 0) begin
      model[slot] += 1;
    end
    if (code == 8'h00) begin
      case (cmd_type)
        cmd_restart: model[9] += 1;
        cmd_prefetch_read: begin
          model[10] += 1;
          model[14] += 32'(size);
        end
        cmd_prefetch_write: begin
          model[11] += 1;
          model[15] += 32'(size);
        end
        cmd_read: begin
          model[12] += 1;
          model[16] += 32'(size);
        end
        cmd_write: begin
          model[13] += 1;
          model[17] += 32'(size);
        end
        default: begin
        end
      endcase
    end
  endtask

  task automatic take_snapshot();
    snapshot = 1'b1;
    snap_model = model;
    snap_cycles = enabled_cycles;
    step();
    snapshot = 1'b0;
  endtask

  task automatic read_words(input logic [79:0] name);
    for (int i = 0; i <= stat_words; i++) begin
      read_index = stat_index_bits'(i);
      step();
      checks++;
      if (i == stat_words - 1) begin
        if (int'(read_data) > snap_cycles || int'(read_data) < snap_cycles - 2) begin
          errors++;
          $display("ERROR %s cycle expected %0d to %0d actual %0d",
                   name, snap_cycles - 2, snap_cycles, read_data);
        end
      end else if (i == stat_words) begin
        if (read_data != '0) begin
          errors++;
          $display("ERROR %s index %0d expected %h actual %h", name, i, 32'h0, read_data);
        end
      end else if (read_data != snap_model[i]) begin
        errors++;
        $display("ERROR %s index %0d expected %h actual %h", name, i, snap_model[i], read_data);
      end
    end
    read_index = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One row, command then response two cycles later
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_row(input stim_row_t row);
    logic [7:0] size;
    logic [5:0] tag;
    rng = xorshift32(rng);
    size = row.size[8] ? rng[7:0] : row.size[7:0];
    tag = row.tag[6] ? {1'b0, rng[12:8]} : row.tag[5:0];
    // Pipeline must be empty before the enable moves
    if (row.enable != enabled_in) begin
      idle(4);
      enabled_in = row.enable;
      idle(2);
    end
    // An invalid type stands for a tag that was never issued
    if (row.cmd_type != cmd_invalid) begin
      command_issue = '{valid: 1'b1, tag: tag, cmd_type: row.cmd_type, real_size_bytes: size};
    end
    step();
    command_issue = '0;
    step();
    response = '{valid: 1'b1, tag: tag, code: response_code_t'(row.code)};
    step();
    response = '0;
    if (row.enable) begin
      update_model(row.cmd_type, size, row.code);
    end
    if (row.check == 2'd1) begin
      idle(4);
      take_snapshot();
    end
    if (row.check != 2'd0) begin
      read_words(row.name);
    end
  endtask

  initial begin
    rstn = 1'b0;
    enabled_in = 1'b0;
    snapshot = 1'b0;
    command_issue = '0;
    response = '0;
    read_index = '0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    repeat (5) @(posedge clock);
    #2;
    rstn = 1'b1;
    enabled_in = 1'b1;
    idle(3);
    take_snapshot();
    read_words("reset");
    for (int r = 0; r < num_rows; r++) begin
      apply_row(rows[r]);
    end
    idle(2);
    $display("Checks %0d, errors %0d, assertion failures %0d",
             checks, errors, DUT.u_chk.failures);
    if (errors == 0 && DUT.u_chk.failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/resp_stats_pkg.sv
verilog/command_tag_table.sv
verilog/response_decode.sv
verilog/response_statistics_control.sv
verilog/stats_readout.sv
verilog/response_stats_top.sv
dv/response_stats_chk.sv
dv/response_stats_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = response_stats_tb
FILELIST  = sim.f
PASS_MSG  = *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the simulation output holds the pass message
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
